// File: sim/vec_mem_model.sv
`timescale 1ns/100ps

`include "vec_cfg.svh"

module vec_mem_model import vec_pkg::*; (
  input  logic     clk_i,
  // LSU side
  input  mem_req_t req_i,
  input  logic     req_valid_i,
  output logic     gnt_o,
  output elem_t    rdata_o,
  // Grant enable from the testbench stall pattern
  input  logic     allow_i
);

  localparam int MEM_WORDS = 1 << `VEC_ADDR_W;

  // Word storage, filled by the testbench before reset ends
  elem_t mem_q [MEM_WORDS];

  // Grant only on cycles the stall pattern allows
  assign gnt_o = req_valid_i && allow_i;

  // Read data is valid exactly one cycle after the grant
  always @(posedge clk_i) begin
    if (gnt_o) begin
      if (req_i.we) begin
        mem_q[req_i.addr] <= req_i.wdata;
      end else begin
        rdata_o <= mem_q[req_i.addr];
      end
    end
  end

endmodule

// File: sim/vec_tb.sv
`timescale 1ns/100ps

`include "vec_cfg.svh"

module vec_tb import vec_pkg::*; ();

  localparam int TIMEOUT   = 2000;
  localparam int SEED      = 16292;
  localparam int MEM_WORDS = 1 << `VEC_ADDR_W;

  logic      clk;
  logic      rst;
  vec_req_t  acc_req;
  logic      acc_req_valid;
  logic      acc_req_ready;
  vec_resp_t acc_resp;
  logic      acc_resp_valid;
  logic      acc_resp_ready;
  mem_req_t  mem_req;
  logic      mem_req_valid;
  logic      mem_gnt;
  logic      mem_allow;
  elem_t     mem_rdata;
  logic      idle;

  integer    seed = SEED;
  integer    stall_seed = SEED + 1;
  logic      stall_en;
  logic      hold_en;
  int        checks;
  int        errors;
  int        test_base;

  // Reference state, updated in request order
  elem_t     ref_vrf [`VEC_NR_VREGS][`VEC_MAX_VL];
  elem_t     ref_mem [MEM_WORDS];
  vec_op_e   exp_op_q [$];
  elem_t     exp_res_q [$];

  vec_top i_vec_top (
    .clk_i           (clk),
    .rst_i           (rst),
    .acc_req_i       (acc_req),
    .acc_req_valid_i (acc_req_valid),
    .acc_req_ready_o (acc_req_ready),
    .acc_resp_o      (acc_resp),
    .acc_resp_valid_o(acc_resp_valid),
    .acc_resp_ready_i(acc_resp_ready),
    .mem_req_o       (mem_req),
    .mem_req_valid_o (mem_req_valid),
    .mem_gnt_i       (mem_gnt),
    .mem_rdata_i     (mem_rdata),
    .idle_o          (idle)
  );

  vec_mem_model i_mem (
    .clk_i      (clk),
    .req_i      (mem_req),
    .req_valid_i(mem_req_valid),
    .gnt_o      (mem_gnt),
    .rdata_o    (mem_rdata),
    .allow_i    (mem_allow)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Grant stalls and response back-pressure, both drawn every cycle
  initial begin
    int r_gnt;
    int r_rdy;
    forever begin
      @(negedge clk);
      r_gnt = $random(stall_seed);
      r_rdy = $random(stall_seed);
      mem_allow = !stall_en || (r_gnt[1:0] != 2'b00);
      acc_resp_ready = !hold_en || (r_rdy[1:0] == 2'b00);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  function automatic elem_t fill_word(int a);
    return {a[15:0], a[15:0] ^ 16'hc35a};
  endfunction

  function automatic elem_t alu_expect(vec_op_e op, elem_t a, elem_t b);
    case (op)
      OP_VADD, OP_VADDX: return a + b;
      OP_VSUB: return a - b;
      OP_VAND: return a & b;
      OP_VOR:  return a | b;
      default: return a ^ b;
    endcase
  endfunction

  // Executes one instruction on the copies and returns the expected result
  function automatic elem_t ref_exec(vec_req_t r);
    mem_addr_t addr;
    elem_t     b;
    for (int e = 0; e < r.vl; e++) begin
      addr = mem_addr_t'(r.scalar) + mem_addr_t'(e);
      b = (r.op == OP_VADDX) ? r.scalar : ref_vrf[r.vs2][e];
      case (r.op)
        OP_VLE:   ref_vrf[r.vd][e] = ref_mem[addr];
        OP_VSE:   ref_mem[addr] = ref_vrf[r.vs1][e];
        OP_VMVXS: b = '0;
        default:  ref_vrf[r.vd][e] = alu_expect(r.op, ref_vrf[r.vs1][e], b);
      endcase
    end
    return (r.op == OP_VMVXS) ? ref_vrf[r.vs1][0] : '0;
  endfunction

  function automatic vec_req_t make_req(vec_op_e op, int vd, int vs1, int vs2, int vl,
                                        elem_t scalar);
    vec_req_t r;
    r.op     = op;
    r.vd     = vreg_idx_t'(vd);
    r.vs1    = vreg_idx_t'(vs1);
    r.vs2    = vreg_idx_t'(vs2);
    r.vl     = vl_t'(vl);
    r.scalar = scalar;
    return r;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Checking and driving
  //////////////////////////////////////////////////////////////////////

  task automatic check_val(string name, logic [63:0] got, logic [63:0] want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("[ERROR] %0t ns %s: got %0h, expected %0h", $time, name, got, want);
    end
  endtask

  task automatic abort_run(string why);
    $display("%0t ns: %s", $time, why);
    $display("TEST FAIL");
    $finish;
  endtask

  task automatic end_test(string name);
    $display("%s: %0d errors", name, errors - test_base);
    test_base = errors;
  endtask

  task automatic check_mem(int lo, int n);
    mem_addr_t a;
    for (int i = 0; i < n; i++) begin
      a = mem_addr_t'(lo + i);
      check_val($sformatf("mem[%h]", a), i_mem.mem_q[a], ref_mem[a]);
    end
  endtask

  // Starts and ends on a falling edge
  task automatic send_req(vec_req_t r);
    int cnt;
    cnt = 0;
    acc_req = r;
    acc_req_valid = 1'b1;
    @(posedge clk);
    while (!acc_req_ready && cnt < TIMEOUT) begin
      cnt++;
      @(posedge clk);
    end
    if (!acc_req_ready) abort_run("request was never accepted");
    exp_op_q.push_back(r.op);
    exp_res_q.push_back(ref_exec(r));
    @(negedge clk);
    acc_req_valid = 1'b0;
  endtask

  task automatic wait_idle();
    int cnt;
    cnt = 0;
    @(negedge clk);
    while (!(idle && exp_op_q.size() == 0) && cnt < TIMEOUT) begin
      cnt++;
      @(negedge clk);
    end
    if (!(idle && exp_op_q.size() == 0)) abort_run("DUT did not drain and return to idle");
  endtask

  // Responses are compared in order against the queued expectations
  always @(posedge clk) begin
    if (!rst && acc_resp_valid && acc_resp_ready) begin
      if (exp_op_q.size() == 0) begin
        errors++;
        $display("%0t ns: response arrived with no request outstanding", $time);
      end else begin
        check_val("acc_resp_o.op", acc_resp.op, exp_op_q.pop_front());
        check_val("acc_resp_o.result", acc_resp.result, exp_res_q.pop_front());
      end
    end
  end

  initial begin
    int    vd;
    int    vs1;
    int    vs2;
    int    vl;
    int    sel;
    elem_t sc;
    rst = 1'b1;
    acc_req = '0;
    acc_req_valid = 1'b0;
    acc_resp_ready = 1'b1;
    mem_allow = 1'b1;
    stall_en = 1'b0;
    hold_en = 1'b0;
    checks = 0;
    errors = 0;
    test_base = 0;
    for (int a = 0; a < MEM_WORDS; a++) begin
      ref_mem[a] = fill_word(a);
      i_mem.mem_q[a] = ref_mem[a];
    end
    // Random operand region at 0x100
    for (int a = 16'h100; a < 16'h140; a++) begin
      ref_mem[a] = $random(seed);
      i_mem.mem_q[a] = ref_mem[a];
    end
    for (int r = 0; r < `VEC_NR_VREGS; r++) begin
      for (int e = 0; e < `VEC_MAX_VL; e++) begin
        ref_vrf[r][e] = '0;
      end
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    check_val("idle_o", idle, 1'b1);
    check_val("acc_resp_valid_o", acc_resp_valid, 1'b0);
    check_val("mem_req_valid_o", mem_req_valid, 1'b0);
    rst = 1'b0;
    end_test("reset state");

    for (int r = 0; r < `VEC_NR_VREGS; r++) begin
      send_req(make_req(OP_VLE, r, 0, 0, 8, 32'h100 + 8 * r));
      send_req(make_req(OP_VMVXS, 0, r, 0, 1, '0));
    end
    wait_idle();
    end_test("load and scalar move");

    // Enum values 0 to 5 are the six ALU ops
    for (int k = 0; k < 6; k++) begin
      vd = $random(seed);
      vs1 = $random(seed);
      vs2 = $random(seed);
      vl = ($random(seed) & 7) + 1;
      sc = $random(seed);
      send_req(make_req(vec_op_e'(k), vd, vs1, vs2, vl, sc));
      send_req(make_req(OP_VSE, 0, vd, 0, 8, 32'h200 + 8 * k));
    end
    wait_idle();
    check_mem(16'h200, 48);
    end_test("ALU ops");

    stall_en = 1'b1;
    vs1 = $random(seed);
    send_req(make_req(OP_VSE, 0, vs1, 0, 8, 32'h300));
    wait_idle();
    check_mem(16'h300, 8);
    end_test("store under grant stalls");

    // Load, dependent add, store, all back to back
    send_req(make_req(OP_VLE, 1, 0, 0, 8, 32'h110));
    send_req(make_req(OP_VADD, 2, 1, 3, 8, '0));
    send_req(make_req(OP_VSE, 0, 2, 0, 8, 32'h400));
    wait_idle();
    check_mem(16'h400, 8);
    stall_en = 1'b0;
    end_test("dependent sequence");

    hold_en = 1'b1;
    for (int i = 0; i < 12; i++) begin
      sel = $random(seed) & 7;
      vd = $random(seed);
      vs1 = $random(seed);
      vs2 = $random(seed);
      vl = ($random(seed) & 7) + 1;
      sc = $random(seed);
      send_req(make_req((sel < 6) ? vec_op_e'(sel) : OP_VMVXS, vd, vs1, vs2, vl, sc));
    end
    wait_idle();
    hold_en = 1'b0;
    end_test("response back-pressure");

    wait_idle();
    check_mem(0, MEM_WORDS);
    end_test("idle and final memory");

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: source/vec_cfg.svh
`ifndef VEC_CFG_SVH
`define VEC_CFG_SVH

//////////////////////////////////////////////////////////////////////
// Vector register file geometry
//////////////////////////////////////////////////////////////////////

// Architectural vector registers
`define VEC_NR_VREGS 8

// Elements held by one vector register
`define VEC_MAX_VL 8

//////////////////////////////////////////////////////////////////////
// Datapath and memory widths
//////////////////////////////////////////////////////////////////////

`define VEC_ELEN 32
`define VEC_ADDR_W 16

`endif

// File: source/vec_dispatcher.sv
`timescale 1ns/100ps

module vec_dispatcher import vec_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_i,
  // Scalar core side
  input  vec_req_t  acc_req_i,
  input  logic      acc_req_valid_i,
  output logic      acc_req_ready_o,
  output vec_resp_t acc_resp_o,
  output logic      acc_resp_valid_o,
  input  logic      acc_resp_ready_i,
  // Sequencer side
  output vec_req_t  seq_req_o,
  output logic      seq_req_valid_o,
  input  logic      seq_req_ready_i,
  input  elem_t     scalar_resp_i,
  input  logic      scalar_resp_valid_i
);

  logic      resp_valid_q;
  logic      wait_scalar_q;
  vec_resp_t resp_q;
  logic      busy;
  logic      req_fire;
  logic      resp_fire;
  logic      scalar_fire;

  // One instruction in the dispatcher at a time
  assign busy = resp_valid_q || wait_scalar_q;

  assign seq_req_o       = acc_req_i;
  assign seq_req_valid_o = acc_req_valid_i && !busy;
  assign acc_req_ready_o = !busy && seq_req_ready_i;

  assign req_fire    = acc_req_valid_i && acc_req_ready_o;
  assign resp_fire   = resp_valid_q && acc_resp_ready_i;
  assign scalar_fire = wait_scalar_q && scalar_resp_valid_i;

  assign acc_resp_o       = resp_q;
  assign acc_resp_valid_o = resp_valid_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      resp_valid_q  <= 1'b0;
      wait_scalar_q <= 1'b0;
    end else begin
      if (resp_fire) begin
        resp_valid_q <= 1'b0;
      end
      if (req_fire) begin
        // Scalar moves answer only once element 0 comes back
        if (acc_req_i.op == OP_VMVXS) begin
          wait_scalar_q <= 1'b1;
        end else begin
          resp_valid_q <= 1'b1;
        end
      end
      if (scalar_fire) begin
        wait_scalar_q <= 1'b0;
        resp_valid_q  <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      resp_q.op     <= acc_req_i.op;
      resp_q.result <= '0;
    end
    if (scalar_fire) begin
      resp_q.result <= scalar_resp_i;
    end
  end

  // A stalled response must not change under the core
  resp_stable_a: assert property (@(posedge clk_i) disable iff (rst_i)
    acc_resp_valid_o && !acc_resp_ready_i |=> acc_resp_valid_o && $stable(acc_resp_o));

endmodule

// File: source/vec_lane.sv
`timescale 1ns/100ps

`include "vec_cfg.svh"

module vec_lane import vec_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_i,
  // Sequencer side
  input  pe_req_t   pe_req_i,
  input  logic      req_valid_i,
  output logic      done_o,
  // Load write-back from the LSU
  input  logic      ld_wr_valid_i,
  input  vreg_idx_t ld_wr_vreg_i,
  input  elem_idx_t ld_wr_idx_i,
  input  elem_t     ld_wr_data_i,
  // Store and scalar read port
  input  vreg_idx_t st_rd_vreg_i,
  input  elem_idx_t st_rd_idx_i,
  output elem_t     st_rd_data_o
);

  //////////////////////////////////////////////////////////////////////
  // Instruction state
  //////////////////////////////////////////////////////////////////////

  elem_t     vrf_q [`VEC_NR_VREGS][`VEC_MAX_VL];
  pe_req_t   req_q;
  logic      busy_q;
  elem_idx_t cnt_q;
  logic      last;
  logic      alu_we;
  elem_t     opa;
  elem_t     opb;
  elem_t     alu_res;

  // Zero-length instructions finish after a single cycle
  assign last   = (req_q.req.vl == '0) || ({1'b0, cnt_q} == req_q.req.vl - 1'b1);
  assign alu_we = busy_q && (req_q.req.vl != '0);
  assign done_o = busy_q && last;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_q <= 1'b0;
    end else if (req_valid_i) begin
      busy_q <= 1'b1;
    end else if (done_o) begin
      busy_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      req_q <= pe_req_i;
      cnt_q <= '0;
    end else if (busy_q) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Element-serial ALU
  //////////////////////////////////////////////////////////////////////

  assign opa = vrf_q[req_q.req.vs1][cnt_q];
  assign opb = (req_q.req.op == OP_VADDX) ? req_q.req.scalar : vrf_q[req_q.req.vs2][cnt_q];

  always_comb begin
    unique case (req_q.req.op)
      OP_VADD, OP_VADDX: alu_res = opa + opb;
      OP_VSUB: alu_res = opa - opb;
      OP_VAND: alu_res = opa & opb;
      OP_VOR:  alu_res = opa | opb;
      OP_VXOR: alu_res = opa ^ opb;
      default: alu_res = '0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Register file
  //////////////////////////////////////////////////////////////////////

  // Two write ports, ALU result and load data
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int r = 0; r < `VEC_NR_VREGS; r++) begin
        for (int e = 0; e < `VEC_MAX_VL; e++) begin
          vrf_q[r][e] <= '0;
        end
      end
    end else begin
      if (alu_we) begin
        vrf_q[req_q.req.vd][cnt_q] <= alu_res;
      end
      if (ld_wr_valid_i) begin
        vrf_q[ld_wr_vreg_i][ld_wr_idx_i] <= ld_wr_data_i;
      end
    end
  end

  assign st_rd_data_o = vrf_q[st_rd_vreg_i][st_rd_idx_i];

  // Hazard tracking upstream keeps loads away from the ALU destination
  no_wr_collision_a: assert property (@(posedge clk_i) disable iff (rst_i)
    alu_we && ld_wr_valid_i |-> ld_wr_vreg_i != req_q.req.vd);

endmodule

// File: source/vec_lsu.sv
`timescale 1ns/100ps

`include "vec_cfg.svh"

module vec_lsu import vec_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_i,
  // Sequencer side
  input  pe_req_t   pe_req_i,
  input  logic      req_valid_i,
  output logic      done_o,
  output elem_t     scalar_o,
  output logic      scalar_valid_o,
  // Lane ports
  output logic      ld_wr_valid_o,
  output vreg_idx_t ld_wr_vreg_o,
  output elem_idx_t ld_wr_idx_o,
  output elem_t     ld_wr_data_o,
  output vreg_idx_t st_rd_vreg_o,
  output elem_idx_t st_rd_idx_o,
  input  elem_t     st_rd_data_i,
  // Word memory
  output mem_req_t  mem_req_o,
  output logic      mem_req_valid_o,
  input  logic      mem_gnt_i,
  input  elem_t     mem_rdata_i
);

  lsu_state_e state_q;
  pe_req_t    req_q;
  vl_t        issued_q;   // accesses granted so far
  logic       rd_pend_q;
  elem_idx_t  rd_idx_q;
  logic       mem_fire;

  assign mem_req_valid_o = (state_q == LOAD || state_q == STORE) && (issued_q < req_q.req.vl);
  assign mem_fire        = mem_req_valid_o && mem_gnt_i;

  always_comb begin
    mem_req_o.we    = (state_q == STORE);
    mem_req_o.addr  = mem_addr_t'(req_q.req.scalar) + mem_addr_t'(issued_q);
    mem_req_o.wdata = st_rd_data_i;
  end

  // Read port serves store data and the element 0 scalar move
  assign st_rd_vreg_o = req_q.req.vs1;
  assign st_rd_idx_o  = (state_q == SCALAR) ? '0 : elem_idx_t'(issued_q);

  // Read data lands one cycle after the grant
  assign ld_wr_valid_o = rd_pend_q;
  assign ld_wr_vreg_o  = req_q.req.vd;
  assign ld_wr_idx_o   = rd_idx_q;
  assign ld_wr_data_o  = mem_rdata_i;

  assign scalar_o       = st_rd_data_i;
  assign scalar_valid_o = (state_q == SCALAR);

  always_comb begin
    unique case (state_q)
      LOAD: begin
        done_o = (req_q.req.vl == '0) ||
                 (rd_pend_q && ({1'b0, rd_idx_q} == req_q.req.vl - 1'b1));
      end
      STORE:   done_o = (req_q.req.vl == '0) || (mem_fire && issued_q == req_q.req.vl - 1'b1);
      SCALAR:  done_o = 1'b1;
      default: done_o = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q   <= IDLE;
      rd_pend_q <= 1'b0;
    end else begin
      rd_pend_q <= mem_fire && (state_q == LOAD);
      if (state_q == IDLE) begin
        if (req_valid_i) begin
          unique case (pe_req_i.req.op)
            OP_VLE:   state_q <= LOAD;
            OP_VSE:   state_q <= STORE;
            OP_VMVXS: state_q <= SCALAR;
            default:  state_q <= IDLE;
          endcase
        end
      end else if (done_o) begin
        state_q <= IDLE;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      req_q    <= pe_req_i;
      issued_q <= '0;
    end else if (mem_fire) begin
      issued_q <= issued_q + 1'b1;
      rd_idx_q <= elem_idx_t'(issued_q);
    end
  end

  // Store data comes from a register the sequencer keeps frozen
  mem_req_stable_a: assert property (@(posedge clk_i) disable iff (rst_i)
    mem_req_valid_o && !mem_gnt_i |=> mem_req_valid_o && $stable(mem_req_o));

  vl_range_a: assert property (@(posedge clk_i) disable iff (rst_i)
    req_valid_i |-> pe_req_i.req.vl <= `VEC_MAX_VL);

endmodule

// File: source/vec_pkg.sv
`include "vec_cfg.svh"

package vec_pkg;

  //////////////////////////////////////////////////////////////////////
  // Scalar types
  //////////////////////////////////////////////////////////////////////

  typedef logic [`VEC_ELEN-1:0] elem_t;
  typedef logic [$clog2(`VEC_NR_VREGS)-1:0] vreg_idx_t;

  // Vector length, 0 up to VEC_MAX_VL inclusive
  typedef logic [$clog2(`VEC_MAX_VL):0] vl_t;
  typedef logic [$clog2(`VEC_MAX_VL)-1:0] elem_idx_t;

  // Word address on the memory port
  typedef logic [`VEC_ADDR_W-1:0] mem_addr_t;

  // Supported vector operations
  typedef enum logic [3:0] {
    OP_VADD  = 4'd0,
    OP_VSUB  = 4'd1,
    OP_VAND  = 4'd2,
    OP_VOR   = 4'd3,
    OP_VXOR  = 4'd4,
    OP_VADDX = 4'd5,
    OP_VLE   = 4'd6,
    OP_VSE   = 4'd7,
    OP_VMVXS = 4'd8
  } vec_op_e;

  //////////////////////////////////////////////////////////////////////
  // Request and response bundles
  //////////////////////////////////////////////////////////////////////

  // Stores and scalar moves take their source register from vs1
  typedef struct packed {
    vec_op_e   op;
    vreg_idx_t vd;
    vreg_idx_t vs1;
    vreg_idx_t vs2;
    vl_t       vl;
    elem_t     scalar;  // scalar operand or memory base address
  } vec_req_t;

  typedef struct packed {
    vec_op_e op;
    elem_t   result;
  } vec_resp_t;

  // Issued instruction plus the running slot it occupies
  typedef struct packed {
    vec_req_t req;
    logic     slot;
  } pe_req_t;

  typedef struct packed {
    logic      we;
    mem_addr_t addr;
    elem_t     wdata;
  } mem_req_t;

  typedef enum logic [1:0] {
    IDLE,
    LOAD,
    STORE,
    SCALAR
  } lsu_state_e;

endpackage

// File: source/vec_sequencer.sv
`timescale 1ns/100ps

`include "vec_cfg.svh"

module vec_sequencer import vec_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_i,
  // Dispatcher side
  input  vec_req_t seq_req_i,
  input  logic     seq_req_valid_i,
  output logic     seq_req_ready_o,
  output elem_t    scalar_resp_o,
  output logic     scalar_resp_valid_o,
  output logic     idle_o,
  // Processing elements
  output pe_req_t  pe_req_o,
  output logic     lane_req_valid_o,
  output logic     lsu_req_valid_o,
  input  logic     lane_done_i,
  input  logic     lsu_done_i,
  input  elem_t    lsu_scalar_i,
  input  logic     lsu_scalar_valid_i
);

  typedef logic [`VEC_NR_VREGS-1:0] vreg_mask_t;

  localparam logic SLOT_LANE = 1'b0;
  localparam logic SLOT_LSU  = 1'b1;

  function automatic vreg_mask_t vreg_bit(vreg_idx_t idx);
    return vreg_mask_t'(1) << idx;
  endfunction

  logic [1:0] busy_q;
  logic [1:0] done;
  vreg_mask_t use_q [2];
  vreg_mask_t new_use;
  logic       target;
  logic       hazard;
  logic       issue;

  assign done = {lsu_done_i, lane_done_i};

  // Registers touched by the incoming instruction, reads and writes alike
  always_comb begin
    unique case (seq_req_i.op)
      OP_VADD, OP_VSUB, OP_VAND, OP_VOR, OP_VXOR: begin
        new_use = vreg_bit(seq_req_i.vd) | vreg_bit(seq_req_i.vs1) | vreg_bit(seq_req_i.vs2);
      end
      OP_VADDX: new_use = vreg_bit(seq_req_i.vd) | vreg_bit(seq_req_i.vs1);
      OP_VLE:   new_use = vreg_bit(seq_req_i.vd);
      OP_VSE, OP_VMVXS: new_use = vreg_bit(seq_req_i.vs1);
      default:  new_use = '0;
    endcase
  end

  assign target = (seq_req_i.op inside {OP_VLE, OP_VSE, OP_VMVXS}) ? SLOT_LSU : SLOT_LANE;

  // Conflict with whatever runs in the other unit
  assign hazard = busy_q[!target] && |(new_use & use_q[!target]);

  assign seq_req_ready_o = !busy_q[target] && !hazard;
  assign issue           = seq_req_valid_i && seq_req_ready_o;

  assign pe_req_o         = '{req: seq_req_i, slot: target};
  assign lane_req_valid_o = issue && (target == SLOT_LANE);
  assign lsu_req_valid_o  = issue && (target == SLOT_LSU);

  assign scalar_resp_o       = lsu_scalar_i;
  assign scalar_resp_valid_o = lsu_scalar_valid_i;
  assign idle_o              = ~|busy_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_q <= '0;
    end else begin
      busy_q <= busy_q & ~done;
      if (issue) begin
        busy_q[target] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue) begin
      use_q[pe_req_o.slot] <= new_use;
    end
  end

  // Busy view must match the units, or a valid could reach a busy unit
  property done_while_busy_p(logic unit_done, logic unit_busy);
    @(posedge clk_i) disable iff (rst_i) unit_done |-> unit_busy;
  endproperty

  lane_done_busy_a: assert property (done_while_busy_p(lane_done_i, busy_q[SLOT_LANE]));
  lsu_done_busy_a:  assert property (done_while_busy_p(lsu_done_i, busy_q[SLOT_LSU]));

endmodule

// File: source/vec_top.sv
`timescale 1ns/100ps

module vec_top import vec_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_i,
  // Scalar core
  input  vec_req_t  acc_req_i,
  input  logic      acc_req_valid_i,
  output logic      acc_req_ready_o,
  output vec_resp_t acc_resp_o,
  output logic      acc_resp_valid_o,
  input  logic      acc_resp_ready_i,
  // Word memory
  output mem_req_t  mem_req_o,
  output logic      mem_req_valid_o,
  input  logic      mem_gnt_i,
  input  elem_t     mem_rdata_i,
  output logic      idle_o
);

  //////////////////////////////////////////////////////////////////////
  // Interconnect
  //////////////////////////////////////////////////////////////////////

  vec_req_t  seq_req;
  logic      seq_req_valid;
  logic      seq_req_ready;
  elem_t     scalar_resp;
  logic      scalar_resp_valid;
  pe_req_t   pe_req;
  logic      lane_req_valid;
  logic      lsu_req_valid;
  logic      lane_done;
  logic      lsu_done;
  elem_t     lsu_scalar;
  logic      lsu_scalar_valid;
  logic      ld_wr_valid;
  vreg_idx_t ld_wr_vreg;
  elem_idx_t ld_wr_idx;
  elem_t     ld_wr_data;
  vreg_idx_t st_rd_vreg;
  elem_idx_t st_rd_idx;
  elem_t     st_rd_data;

  vec_dispatcher i_dispatcher (
    .clk_i              (clk_i),
    .rst_i              (rst_i),
    .acc_req_i          (acc_req_i),
    .acc_req_valid_i    (acc_req_valid_i),
    .acc_req_ready_o    (acc_req_ready_o),
    .acc_resp_o         (acc_resp_o),
    .acc_resp_valid_o   (acc_resp_valid_o),
    .acc_resp_ready_i   (acc_resp_ready_i),
    .seq_req_o          (seq_req),
    .seq_req_valid_o    (seq_req_valid),
    .seq_req_ready_i    (seq_req_ready),
    .scalar_resp_i      (scalar_resp),
    .scalar_resp_valid_i(scalar_resp_valid)
  );

  vec_sequencer i_sequencer (
    .clk_i              (clk_i),
    .rst_i              (rst_i),
    .seq_req_i          (seq_req),
    .seq_req_valid_i    (seq_req_valid),
    .seq_req_ready_o    (seq_req_ready),
    .scalar_resp_o      (scalar_resp),
    .scalar_resp_valid_o(scalar_resp_valid),
    .idle_o             (idle_o),
    .pe_req_o           (pe_req),
    .lane_req_valid_o   (lane_req_valid),
    .lsu_req_valid_o    (lsu_req_valid),
    .lane_done_i        (lane_done),
    .lsu_done_i         (lsu_done),
    .lsu_scalar_i       (lsu_scalar),
    .lsu_scalar_valid_i (lsu_scalar_valid)
  );

  vec_lane i_lane (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .pe_req_i     (pe_req),
    .req_valid_i  (lane_req_valid),
    .done_o       (lane_done),
    .ld_wr_valid_i(ld_wr_valid),
    .ld_wr_vreg_i (ld_wr_vreg),
    .ld_wr_idx_i  (ld_wr_idx),
    .ld_wr_data_i (ld_wr_data),
    .st_rd_vreg_i (st_rd_vreg),
    .st_rd_idx_i  (st_rd_idx),
    .st_rd_data_o (st_rd_data)
  );

  vec_lsu i_lsu (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .pe_req_i       (pe_req),
    .req_valid_i    (lsu_req_valid),
    .done_o         (lsu_done),
    .scalar_o       (lsu_scalar),
    .scalar_valid_o (lsu_scalar_valid),
    .ld_wr_valid_o  (ld_wr_valid),
    .ld_wr_vreg_o   (ld_wr_vreg),
    .ld_wr_idx_o    (ld_wr_idx),
    .ld_wr_data_o   (ld_wr_data),
    .st_rd_vreg_o   (st_rd_vreg),
    .st_rd_idx_o    (st_rd_idx),
    .st_rd_data_i   (st_rd_data),
    .mem_req_o      (mem_req_o),
    .mem_req_valid_o(mem_req_valid_o),
    .mem_gnt_i      (mem_gnt_i),
    .mem_rdata_i    (mem_rdata_i)
  );

endmodule

// File: vec_unit.f
+incdir+source
source/vec_pkg.sv
source/vec_dispatcher.sv
source/vec_sequencer.sv
source/vec_lane.sv
source/vec_lsu.sv
source/vec_top.sv
sim/vec_mem_model.sv
sim/vec_tb.sv
